//--- common/pic_map_pkg.sv
package pic_map_pkg;

  ////////////////////
  // Field widths
  ////////////////////

  localparam int prio_bits = 4;   // Priority field
  localparam int id_bits   = 8;   // Claim ID for up to 256 sources
  localparam int addr_bits = 32;
  localparam int data_bits = 32;

  // Highest priority value in normal order
  localparam int max_prio = 15;

  ////////////////////
  // Register groups
  ////////////////////

  localparam logic [addr_bits-1:0] off_priority  = 32'h0000_0000;  // One word per source
  localparam logic [addr_bits-1:0] off_pending   = 32'h0000_1000;  // 32 sources per word
  localparam logic [addr_bits-1:0] off_enable    = 32'h0000_2000;
  localparam logic [addr_bits-1:0] off_config    = 32'h0000_3000;  // Single global word
  localparam logic [addr_bits-1:0] off_gw_config = 32'h0000_4000;
  localparam logic [addr_bits-1:0] off_gw_clear  = 32'h0000_5000;  // Write only

  ////////////////////
  // Address decode
  ////////////////////

  // Bits from region_lsb up must equal the base address
  localparam int region_lsb = 15;

  // Group select within the region
  localparam int grp_msb  = 14;
  localparam int grp_lsb  = 12;
  localparam int grp_bits = grp_msb - grp_lsb + 1;

  // Word index inside a group
  localparam int idx_msb  = 11;
  localparam int idx_lsb  = 2;
  localparam int idx_bits = idx_msb - idx_lsb + 1;

  // Group codes as seen in the address
  localparam logic [grp_bits-1:0] grp_priority  = off_priority[grp_msb:grp_lsb];
  localparam logic [grp_bits-1:0] grp_pending   = off_pending[grp_msb:grp_lsb];
  localparam logic [grp_bits-1:0] grp_enable    = off_enable[grp_msb:grp_lsb];
  localparam logic [grp_bits-1:0] grp_config    = off_config[grp_msb:grp_lsb];
  localparam logic [grp_bits-1:0] grp_gw_config = off_gw_config[grp_msb:grp_lsb];
  localparam logic [grp_bits-1:0] grp_gw_clear  = off_gw_clear[grp_msb:grp_lsb];

endpackage

//--- common/pic_types_pkg.sv
package pic_types_pkg;

  typedef logic [pic_map_pkg::prio_bits-1:0] prio_t;
  typedef logic [pic_map_pkg::id_bits-1:0]   claim_id_t;

  ////////////////////
  // Write data views
  ////////////////////

  // Word written to a priority register
  typedef struct packed {
    logic [pic_map_pkg::data_bits-pic_map_pkg::prio_bits-1:0] pad;
    prio_t                                                    prio;
  } wdata_prio_t;

  // Word written to a gateway configuration register
  typedef struct packed {
    logic [pic_map_pkg::data_bits-3:0] pad;
    logic                              gw_type;   // 1 selects edge
    logic                              polarity;  // 1 selects active low
  } wdata_gw_t;

  typedef union packed {
    wdata_prio_t prio_view;
    wdata_gw_t   gw_view;
  } wdata_u;

  ////////////////////
  // AXI4-Lite
  ////////////////////

  // Master to slave
  typedef struct packed {
    logic [pic_map_pkg::addr_bits-1:0] awaddr;
    logic                              awvalid;
    logic [pic_map_pkg::data_bits-1:0] wdata;
    logic                              wvalid;
    logic                              bready;
    logic [pic_map_pkg::addr_bits-1:0] araddr;
    logic                              arvalid;
    logic                              rready;
  } axil_req_t;

  // Slave to master with OKAY as the only response
  typedef struct packed {
    logic                              awready;
    logic                              wready;
    logic                              bvalid;
    logic                              arready;
    logic                              rvalid;
    logic [pic_map_pkg::data_bits-1:0] rdata;
  } axil_rsp_t;

  ////////////////////
  // Core side
  ////////////////////

  typedef struct packed {
    prio_t meipt;     // Priority threshold
    prio_t meicurpl;  // Current priority level
  } core_ctl_t;

  typedef struct packed {
    logic      mexintpend;
    claim_id_t claim_id;
    prio_t     pl;
    logic      mhwakeup;
  } core_int_t;

endpackage

//--- design/pic_reg_file.sv
`timescale 1ns/1ps

module pic_reg_file #(
  parameter int                                num_int   = 32,
  parameter logic [pic_map_pkg::addr_bits-1:0] base_addr = 32'hf00c_0000
) (
  input  logic                               clk,
  input  logic                               rst,
  input  pic_types_pkg::axil_req_t           axil_req,
  output pic_types_pkg::axil_rsp_t           axil_rsp,
  input  logic [num_int-1:0]                 pending,
  output pic_types_pkg::prio_t [num_int-1:0] prio,
  output logic [num_int-1:0]                 enable,
  output logic [num_int-1:0]                 gw_polarity,
  output logic [num_int-1:0]                 gw_edge,
  output logic [num_int-1:0]                 gw_clear,
  output logic                               reverse_order
);
  import pic_map_pkg::*;
  import pic_types_pkg::*;

  localparam int src_bits  = $clog2(num_int);
  localparam int num_words = (num_int + 31) / 32;  // Pending words

  wdata_u                  wd;
  logic                    aw_hit;
  logic [grp_bits-1:0]     aw_grp;
  logic [idx_bits-1:0]     aw_idx;
  logic                    wr_acc;
  logic                    bvalid_q;
  logic                    cfg_q;
  logic                    ar_hit;
  logic [grp_bits-1:0]     ar_grp;
  logic [idx_bits-1:0]     ar_idx;
  logic                    rd_acc;
  logic                    rvalid_q;
  logic [data_bits-1:0]    rd_data;
  logic [data_bits-1:0]    rdata_q;
  logic [num_words*32-1:0] pend_ext;

  ////////////////////
  // Write decode
  ////////////////////

  assign wd     = wdata_u'(axil_req.wdata);
  assign aw_hit = axil_req.awaddr[addr_bits-1:region_lsb] == base_addr[addr_bits-1:region_lsb];
  assign aw_grp = axil_req.awaddr[grp_msb:grp_lsb];
  assign aw_idx = axil_req.awaddr[idx_msb:idx_lsb];

  // AW and W taken together only while no response is outstanding
  assign wr_acc = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;

  for (genvar i = 0; i < num_int; i++) begin : g_src
    if (i == 0) begin : g_zero
      assign prio[i]        = '0;  // Reserved source
      assign enable[i]      = 1'b0;
      assign gw_polarity[i] = 1'b0;
      assign gw_edge[i]     = 1'b0;
      assign gw_clear[i]    = 1'b0;
    end else begin : g_reg
      logic  sel;
      prio_t prio_q;
      logic  en_q;
      logic  pol_q;
      logic  edge_q;

      assign sel = wr_acc & aw_hit & (aw_idx == idx_bits'(i));

      always_ff @(posedge clk) begin
        if (rst) begin
          prio_q <= '0;
          en_q   <= 1'b0;
          pol_q  <= 1'b0;
          edge_q <= 1'b0;
        end else if (sel) begin
          case (aw_grp)
            grp_priority:  prio_q <= wd.prio_view.prio;
            grp_enable:    en_q   <= axil_req.wdata[0];
            grp_gw_config: begin
              pol_q  <= wd.gw_view.polarity;
              edge_q <= wd.gw_view.gw_type;
            end
            default: ;
          endcase
        end
      end

      assign prio[i]        = prio_q;
      assign enable[i]      = en_q;
      assign gw_polarity[i] = pol_q;
      assign gw_edge[i]     = edge_q;
      assign gw_clear[i]    = sel & (aw_grp == grp_gw_clear);  // Pulse on the accepting cycle
    end
  end

  // Bit 0 of the global configuration reverses priority order
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= 1'b0;
    end else if (wr_acc & aw_hit & (aw_grp == grp_config) & (aw_idx == '0)) begin
      cfg_q <= axil_req.wdata[0];
    end
  end

  assign reverse_order = cfg_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid_q <= 1'b0;
    end else if (wr_acc) begin
      bvalid_q <= 1'b1;
    end else if (axil_req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  assign ar_hit   = axil_req.araddr[addr_bits-1:region_lsb] == base_addr[addr_bits-1:region_lsb];
  assign ar_grp   = axil_req.araddr[grp_msb:grp_lsb];
  assign ar_idx   = axil_req.araddr[idx_msb:idx_lsb];
  assign rd_acc   = axil_req.arvalid & ~rvalid_q;
  assign pend_ext = (num_words*32)'(pending);

  always_comb begin
    rd_data = '0;
    if (ar_hit) begin
      case (ar_grp)
        grp_priority: begin
          if (ar_idx < num_int) rd_data[prio_bits-1:0] = prio[ar_idx[src_bits-1:0]];
        end
        grp_enable: begin
          if (ar_idx < num_int) rd_data[0] = enable[ar_idx[src_bits-1:0]];
        end
        grp_gw_config: begin
          if (ar_idx < num_int) begin
            rd_data[0] = gw_polarity[ar_idx[src_bits-1:0]];
            rd_data[1] = gw_edge[ar_idx[src_bits-1:0]];
          end
        end
        grp_config: begin
          if (ar_idx == '0) rd_data[0] = cfg_q;
        end
        grp_pending: begin
          // Word picked by address bits 5:2 with the higher index bits at zero
          for (int w = 0; w < num_words; w++) begin
            if (ar_idx == idx_bits'(w)) rd_data = pend_ext[32*w +: 32];
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (rd_acc) begin
      rvalid_q <= 1'b1;
    end else if (axil_req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // Data sampled at acceptance and held while R waits
  always_ff @(posedge clk) begin
    if (rd_acc) begin
      rdata_q <= rd_data;
    end
  end

  assign axil_rsp.awready = wr_acc;
  assign axil_rsp.wready  = wr_acc;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.arready = ~rvalid_q;
  assign axil_rsp.rvalid  = rvalid_q;
  assign axil_rsp.rdata   = rdata_q;

endmodule

//--- design/gateway/pic_gateway_bank.sv
`timescale 1ns/1ps

module pic_gateway_bank #(
  parameter int num_int = 32
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [num_int-1:0] ext_irq,
  input  logic [num_int-1:0] gw_polarity,
  input  logic [num_int-1:0] gw_edge,
  input  logic [num_int-1:0] gw_clear,
  output logic [num_int-1:0] pending
);

  // Source 0 is reserved, so the bank covers sources 1 and up
  logic [num_int-1:1] sync1_q;
  logic [num_int-1:1] sync2_q;
  logic [num_int-1:1] req;       // Synchronized active-high request
  logic [num_int-1:1] sticky_q;  // Edge capture

  ////////////////////
  // Synchronizer
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= ext_irq[num_int-1:1];
      sync2_q <= sync1_q;
    end
  end

  assign req = sync2_q ^ gw_polarity[num_int-1:1];  // Active low sources flip here

  ////////////////////
  // Gateways
  ////////////////////

  // Edge mode holds the request until software clears it
  // Level mode keeps the capture flop empty
  always_ff @(posedge clk) begin
    if (rst) begin
      sticky_q <= '0;
    end else begin
      sticky_q <= gw_edge[num_int-1:1] & (req | (sticky_q & ~gw_clear[num_int-1:1]));
    end
  end

  assign pending[0]           = 1'b0;  // Never pends
  assign pending[num_int-1:1] = req | sticky_q;

endmodule

//--- design/pic_arbiter_tree.sv
`timescale 1ns/1ps

module pic_arbiter_tree #(
  parameter int num_int = 32
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [num_int-1:0]                 pending,
  input  pic_types_pkg::prio_t [num_int-1:0] prio,
  input  logic [num_int-1:0]                 enable,
  input  logic                               reverse_order,
  input  pic_types_pkg::core_ctl_t           core_ctl,
  output pic_types_pkg::core_int_t           core_int
);
  import pic_map_pkg::*;
  import pic_types_pkg::*;

  localparam int levels = $clog2(num_int);
  localparam int leaves = 1 << levels;

  typedef struct packed {
    prio_t     prio;
    claim_id_t id;
  } cand_t;

  // Side a always holds the lower IDs and keeps ties
  function automatic cand_t pick(cand_t a, cand_t b);
    return (b.prio > a.prio) ? b : a;
  endfunction

  cand_t [2*leaves-1:1] node;  // Heap order with the root at index 1
  cand_t                win;
  prio_t                meipt_eff;
  prio_t                curpl_eff;
  prio_t                pl_d;
  core_int_t            core_int_d;

  ////////////////////
  // Leaves
  ////////////////////

  for (genvar i = 0; i < leaves; i++) begin : g_leaf
    if (i < num_int) begin : g_src
      prio_t eff;
      assign eff = reverse_order ? ~prio[i] : prio[i];
      assign node[leaves+i] = {(pending[i] & enable[i]) ? eff : prio_t'(0), claim_id_t'(i)};
    end else begin : g_pad
      assign node[leaves+i] = {prio_t'(0), claim_id_t'(i)};  // Loses every tie
    end
  end

  // Log-depth reduction
  for (genvar k = 1; k < leaves; k++) begin : g_node
    assign node[k] = pick(node[2*k], node[2*k+1]);
  end

  ////////////////////
  // Core outputs
  ////////////////////

  assign win       = node[1];
  assign meipt_eff = reverse_order ? ~core_ctl.meipt : core_ctl.meipt;
  assign curpl_eff = reverse_order ? ~core_ctl.meicurpl : core_ctl.meicurpl;
  assign pl_d      = reverse_order ? ~win.prio : win.prio;  // Back to software's numbering

  always_comb begin
    core_int_d.mexintpend = (win.prio > meipt_eff) & (win.prio > curpl_eff);
    core_int_d.claim_id   = win.id;
    core_int_d.pl         = pl_d;
    core_int_d.mhwakeup   = pl_d == (reverse_order ? prio_t'(0) : prio_t'(max_prio));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      core_int <= '0;
    end else begin
      core_int <= core_int_d;
    end
  end

endmodule

//--- design/pic_top.sv
`timescale 1ns/1ps

module pic_top #(
  parameter int                                num_int   = 32,
  parameter logic [pic_map_pkg::addr_bits-1:0] base_addr = 32'hf00c_0000
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [num_int-1:0]       ext_irq,
  input  pic_types_pkg::axil_req_t axil_req,
  output pic_types_pkg::axil_rsp_t axil_rsp,
  input  pic_types_pkg::core_ctl_t core_ctl,
  output pic_types_pkg::core_int_t core_int
);
  import pic_types_pkg::*;

  logic [num_int-1:0]  pending;        // Gateway outputs
  prio_t [num_int-1:0] prio;
  logic [num_int-1:0]  enable;
  logic [num_int-1:0]  gw_polarity;
  logic [num_int-1:0]  gw_edge;
  logic [num_int-1:0]  gw_clear;       // One cycle per clear write
  logic                reverse_order;

  ////////////////////
  // Register file
  ////////////////////

  pic_reg_file #(
    .num_int   (num_int),
    .base_addr (base_addr)
  ) i_reg_file (
    .clk           (clk),
    .rst           (rst),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .pending       (pending),
    .prio          (prio),
    .enable        (enable),
    .gw_polarity   (gw_polarity),
    .gw_edge       (gw_edge),
    .gw_clear      (gw_clear),
    .reverse_order (reverse_order)
  );

  pic_gateway_bank #(
    .num_int (num_int)
  ) i_gateway_bank (
    .clk         (clk),
    .rst         (rst),
    .ext_irq     (ext_irq),
    .gw_polarity (gw_polarity),
    .gw_edge     (gw_edge),
    .gw_clear    (gw_clear),
    .pending     (pending)
  );

  // Selection and core interface
  pic_arbiter_tree #(
    .num_int (num_int)
  ) i_arbiter_tree (
    .clk           (clk),
    .rst           (rst),
    .pending       (pending),
    .prio          (prio),
    .enable        (enable),
    .reverse_order (reverse_order),
    .core_ctl      (core_ctl),
    .core_int      (core_int)
  );

endmodule

//--- verification/pic_chk.sv
`timescale 1ns/1ps

module pic_chk (
  input logic                     clk,
  input logic                     rst,
  input pic_types_pkg::axil_req_t axil_req,
  input pic_types_pkg::axil_rsp_t axil_rsp,
  input pic_types_pkg::core_int_t core_int
);

  ////////////////////
  // AXI4-Lite responses
  ////////////////////

  bvalid_hold: assert property (
    @(posedge clk) disable iff (rst)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid
  ) else $error("B valid dropped before B ready");

  rvalid_hold: assert property (
    @(posedge clk) disable iff (rst)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid
  ) else $error("R valid dropped before R ready");

  // B valid only rises after AW and W were taken
  write_accept: assert property (
    @(posedge clk) disable iff (rst)
    $rose(axil_rsp.bvalid) |-> $past(axil_rsp.awready && axil_rsp.wready)
  ) else $error("B valid rose without an accepted write");

  // R valid only rises after AR was taken
  read_accept: assert property (
    @(posedge clk) disable iff (rst)
    $rose(axil_rsp.rvalid) |-> $past(axil_rsp.arready && axil_req.arvalid)
  ) else $error("R valid rose without an accepted read");

  // Data sampled at acceptance must not move while R waits
  rdata_stable: assert property (
    @(posedge clk) disable iff (rst)
    axil_rsp.rvalid && !axil_req.rready |=> $stable(axil_rsp.rdata)
  ) else $error("R data changed while R valid waited");

  ////////////////////
  // Reset and core side
  ////////////////////

  reset_state: assert property (
    @(posedge clk)
    rst |=> !axil_rsp.bvalid && !axil_rsp.rvalid &&
            !core_int.mexintpend && !core_int.mhwakeup
  ) else $error("Outputs not idle after reset");

  // Source 0 is reserved and can never be claimed
  claim_nonzero: assert property (
    @(posedge clk) disable iff (rst)
    core_int.mexintpend |-> core_int.claim_id != '0
  ) else $error("Interrupt request with claim ID 0");

endmodule

bind pic_top pic_chk i_chk (
  .clk      (clk),
  .rst      (rst),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .core_int (core_int)
);

//--- verification/pic_tb.sv
`timescale 1ns/1ps

module pic_tb;
  import pic_map_pkg::*;
  import pic_types_pkg::*;

  localparam int          num_src        = 32;
  localparam logic [31:0] base           = 32'hf00c_0000;
  localparam int          timeout_cycles = 10;

  logic               clk;
  logic               rst;
  logic [num_src-1:0] ext_irq;
  axil_req_t          axil_req;
  axil_rsp_t          axil_rsp;
  core_ctl_t          core_ctl;
  core_int_t          core_int;

  // Reference model of the register state
  prio_t              prio_m [num_src];
  logic [num_src-1:0] en_m;
  logic [num_src-1:0] pol_m;
  logic [num_src-1:0] edge_m;
  logic [num_src-1:0] sticky_m;   // Captured edge requests
  logic               rev_m;

  string       test_name;
  int          checks;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          s;
  int          t;
  logic [31:0] rd;

  pic_top #(
    .num_int   (num_src),
    .base_addr (base)
  ) i_dut (
    .clk      (clk),
    .rst      (rst),
    .ext_irq  (ext_irq),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .core_ctl (core_ctl),
    .core_int (core_int)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Bus access
  ////////////////////

  function automatic logic [31:0] addr_of(input logic [31:0] off, input int idx);
    return base + off + 32'(4 * idx);
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    int n;
    @(negedge clk);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axil_rsp.bvalid && n < timeout_cycles);
    if (axil_rsp.bvalid) begin
      // Open response holds AW and W off while the valids stay high
      check_value("awready", 32'h0, 32'(axil_rsp.awready));
      check_value("wready", 32'h0, 32'(axil_rsp.wready));
    end else begin
      $display("Write to 0x%h got no response within %0d cycles", addr, timeout_cycles);
      errors++;
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    repeat ($urandom_range(2, 0)) @(negedge clk);  // Keep B waiting a little
    axil_req.bready = 1'b1;
    @(negedge clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    int n;
    @(negedge clk);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axil_rsp.rvalid && n < timeout_cycles);
    data = axil_rsp.rdata;
    if (axil_rsp.rvalid) begin
      // Open read data holds AR off while AR valid stays high
      check_value("arready", 32'h0, 32'(axil_rsp.arready));
    end else begin
      $display("Read of 0x%h got no data within %0d cycles", addr, timeout_cycles);
      errors++;
    end
    axil_req.arvalid = 1'b0;
    repeat ($urandom_range(2, 0)) @(negedge clk);  // R data must hold meanwhile
    axil_req.rready = 1'b1;
    @(negedge clk);
    axil_req.rready = 1'b0;
  endtask

  // Register writes that also update the model for sources 1 and up
  task automatic set_prio(input int idx, input logic [31:0] word);
    write_reg(addr_of(off_priority, idx), word);
    if (idx > 0) prio_m[idx] = word[prio_bits-1:0];
  endtask

  task automatic set_enable(input int idx, input logic [31:0] word);
    write_reg(addr_of(off_enable, idx), word);
    if (idx > 0) en_m[idx] = word[0];
  endtask

  task automatic set_gw(input int idx, input logic [31:0] word);
    write_reg(addr_of(off_gw_config, idx), word);
    if (idx > 0) begin
      pol_m[idx]  = word[0];
      edge_m[idx] = word[1];
    end
  endtask

  task automatic set_config(input logic [31:0] word);
    write_reg(addr_of(off_config, 0), word);
    rev_m = word[0];
  endtask

  task automatic clear_all();
    @(negedge clk);
    ext_irq = '0;
    for (int i = 1; i < num_src; i++) begin
      set_enable(i, 0);
      set_gw(i, 0);
    end
    sticky_m = '0;  // Level mode empties the capture flops
  endtask

  ////////////////////
  // Expected outputs
  ////////////////////

  function automatic logic [31:0] pend_model();
    logic [31:0] p;
    p = '0;
    for (int i = 1; i < num_src; i++) begin
      p[i] = (ext_irq[i] ^ pol_m[i]) | (edge_m[i] & sticky_m[i]);
    end
    return p;
  endfunction

  // Rank is the priority seen in normal order
  // Rank 0 never interrupts
  function automatic core_int_t expected_core();
    core_int_t   e;
    logic [31:0] p;
    int          best;
    int          rank;
    int          thr;
    int          cur;
    e    = '0;
    p    = pend_model();
    best = 0;
    for (int i = 1; i < num_src; i++) begin
      rank = rev_m ? max_prio - int'(prio_m[i]) : int'(prio_m[i]);
      if (p[i] && en_m[i] && rank > best) begin  // Strict compare keeps the lower ID
        best       = rank;
        e.claim_id = claim_id_t'(i);
      end
    end
    thr          = rev_m ? max_prio - int'(core_ctl.meipt) : int'(core_ctl.meipt);
    cur          = rev_m ? max_prio - int'(core_ctl.meicurpl) : int'(core_ctl.meicurpl);
    e.pl         = prio_t'(rev_m ? max_prio - best : best);
    e.mexintpend = (best > thr) && (best > cur);
    e.mhwakeup   = e.pl == prio_t'(rev_m ? 0 : max_prio);
    return e;
  endfunction

  task automatic wait_core();
    core_int_t exp;
    int        n;
    n = 0;
    @(negedge clk);
    exp = expected_core();
    while (core_int !== exp && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    check_value("claim_id", 32'(exp.claim_id), 32'(core_int.claim_id));
    check_value("pl", 32'(exp.pl), 32'(core_int.pl));
    check_value("mexintpend", 32'(exp.mexintpend), 32'(core_int.mexintpend));
    check_value("mhwakeup", 32'(exp.mhwakeup), 32'(core_int.mhwakeup));
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("%-12s %s, %0d errors", test_name,
             (errors == test_errors) ? "passed" : "failed", errors - test_errors);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    void'($urandom(32'h2b00_cf78));
    rst      = 1'b1;
    ext_irq  = '0;
    axil_req = '0;
    core_ctl = '0;
    for (int i = 0; i < num_src; i++) prio_m[i] = '0;
    en_m     = '0;
    pol_m    = '0;
    edge_m   = '0;
    sticky_m = '0;
    rev_m    = 1'b0;
    checks   = 0;
    errors   = 0;
    tests_run = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    start_test("readback");
    for (int k = 0; k < 6; k++) begin
      s = $urandom_range(num_src - 1, 1);
      set_prio(s, $urandom);
      read_reg(addr_of(off_priority, s), rd);
      check_value("priority", 32'(prio_m[s]), rd);
      set_enable(s, $urandom);
      read_reg(addr_of(off_enable, s), rd);
      check_value("enable", 32'(en_m[s]), rd);
      set_gw(s, $urandom);
      read_reg(addr_of(off_gw_config, s), rd);
      check_value("gw_config", {30'b0, edge_m[s], pol_m[s]}, rd);
    end
    set_config($urandom | 32'h1);
    read_reg(addr_of(off_config, 0), rd);
    check_value("config", 32'(rev_m), rd);
    set_config(0);
    set_prio(0, 32'hf);
    read_reg(addr_of(off_priority, 0), rd);
    check_value("source 0", 32'h0, rd);
    read_reg(addr_of(32'h6000, 0), rd);
    check_value("unmapped group", 32'h0, rd);
    read_reg(addr_of(off_priority, 64), rd);  // Index past the last source
    check_value("unmapped index", 32'h0, rd);
    read_reg(base ^ 32'h0100_0000, rd);
    check_value("outside region", 32'h0, rd);
    clear_all();
    wait_core();
    finish_test();

    start_test("arbitration");
    for (int r = 0; r < 3; r++) begin
      clear_all();
      for (int k = 0; k < 6; k++) begin
        s = $urandom_range(num_src - 1, 1);
        set_prio(s, (k == 0) ? max_prio : $urandom_range(6, 1));  // Small range forces ties
        set_enable(s, (k == 0) ? 0 : 1);
        ext_irq[s] = 1'b1;
      end
      wait_core();
      s = int'(core_int.claim_id);
      if (s != 0) set_enable(s, 0);  // Next in line takes over
      wait_core();
    end
    finish_test();

    start_test("threshold");
    clear_all();
    s = $urandom_range(num_src - 1, 1);
    set_prio(s, 8);
    set_enable(s, 1);
    ext_irq[s] = 1'b1;
    for (int k = 0; k < 12; k++) begin
      core_ctl.meipt    = prio_t'($urandom_range(max_prio, 0));
      core_ctl.meicurpl = prio_t'($urandom_range(max_prio, 0));
      wait_core();
    end
    finish_test();

    start_test("edge");
    clear_all();
    core_ctl = '0;
    s = $urandom_range(num_src - 1, 1);
    set_gw(s, 32'h2);
    set_prio(s, 5);
    set_enable(s, 1);
    ext_irq[s]  = 1'b1;  // One cycle pulse
    sticky_m[s] = 1'b1;
    @(negedge clk);
    ext_irq[s] = 1'b0;
    wait_core();
    repeat (4) @(negedge clk);
    read_reg(addr_of(off_pending, 0), rd);
    check_value("pending held", pend_model(), rd);
    wait_core();
    write_reg(addr_of(off_gw_clear, s), 32'h0);
    sticky_m[s] = 1'b0;
    wait_core();
    read_reg(addr_of(off_pending, 0), rd);
    check_value("pending cleared", pend_model(), rd);
    t = s % (num_src - 1) + 1;
    set_gw(t, 32'h1);  // Active low and the line is low now
    set_prio(t, 3);
    set_enable(t, 1);
    wait_core();
    read_reg(addr_of(off_pending, 0), rd);
    check_value("active low", pend_model(), rd);
    ext_irq[t] = 1'b1;
    wait_core();
    read_reg(addr_of(off_pending, 0), rd);
    check_value("active low idle", pend_model(), rd);
    finish_test();

    start_test("reverse");
    clear_all();
    set_config(1);
    for (int k = 0; k < 4; k++) begin
      s = $urandom_range(num_src - 1, 1);
      set_prio(s, $urandom_range(max_prio - 1, 1));
      set_enable(s, 1);
      ext_irq[s] = 1'b1;
    end
    for (int k = 0; k < 6; k++) begin
      core_ctl.meipt    = prio_t'($urandom_range(max_prio, 0));
      core_ctl.meicurpl = prio_t'($urandom_range(max_prio, 0));
      wait_core();
    end
    core_ctl = '1;  // Lowest threshold in reverse order
    s = $urandom_range(num_src - 1, 1);
    set_prio(s, 0);
    set_enable(s, 1);
    ext_irq[s] = 1'b1;
    wait_core();
    set_config(0);
    core_ctl = '0;
    set_prio(s, max_prio);
    wait_core();
    finish_test();

    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- flist.f
common/pic_map_pkg.sv
common/pic_types_pkg.sv
design/pic_reg_file.sv
design/gateway/pic_gateway_bank.sv
design/pic_arbiter_tree.sv
design/pic_top.sv
verification/pic_chk.sv
verification/pic_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PIC testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pic_tb -f flist.f \
  -o pic_sim > build.log 2>&1 \
  && ./obj_dir/pic_sim > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -qx "NO ERRORS" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }
